// ==== include/hus_consts.svh ====
`ifndef HUS_CONSTS_SVH
`define HUS_CONSTS_SVH

// voice count and frame rate
`define HUS_CHANNELS     4
`define HUS_FRAME_CYCLES 256

// sample memory
`define HUS_ADDR_W 24   // byte address
`define HUS_MEM_W  16   // memory word
`define HUS_SMP_W  8

// register file and datapath widths
`define HUS_IDX_W  3
`define HUS_FRAC_W 8    // position fraction bits
`define HUS_STEP_W 16   // 8.8 pitch step
`define HUS_VOL_W  8
`define HUS_DAC_W  16

`endif

// ==== hw/hus_pkg.sv ====
`include "hus_consts.svh"

package hus_pkg;

	// register index inside a channel, addr bits 4:2
	typedef enum logic [`HUS_IDX_W-1:0]
	{
		reg_ctrl       = 3'd0,  // active, loop enable, retrigger
		reg_start      = 3'd1,
		reg_end_addr   = 3'd2,
		reg_loop_start = 3'd3,
		reg_step       = 3'd4,
		reg_vol        = 3'd5   // left 7:0, right 15:8
	} hus_reg_e;

	// integer byte address above the fraction
	typedef logic [`HUS_ADDR_W+`HUS_FRAC_W-1:0] hus_pos_t;

	typedef enum logic [1:0]
	{
		v_idle,
		v_fetch,  // memory request outstanding
		v_ready   // done, waiting for ack
	} voice_state_e;

	typedef enum logic [1:0]
	{
		m_wait_frame,
		m_gather,  // waiting for all voices
		m_sum      // ack and frame_done cycle
	} mix_state_e;

endpackage

// ==== hw/hus_voice_if.sv ====
`timescale 1ns/1ns
`include "hus_consts.svh"

interface hus_voice_if;
	// channel setup from the register file
	logic                          active;
	logic                          loop_en;
	logic                          retrig;   // one cycle
	logic [`HUS_ADDR_W-1:0]        start;
	logic [`HUS_ADDR_W-1:0]        end_addr;
	logic [`HUS_ADDR_W-1:0]        loop_start;
	logic [`HUS_STEP_W-1:0]        step;
	logic [`HUS_VOL_W-1:0]         vol_l;
	logic [`HUS_VOL_W-1:0]         vol_r;

	// voice results
	logic                          stop;     // one cycle, end reached without loop
	logic                          done;
	logic signed [`HUS_SMP_W-1:0]  sample;

	// frame handshake from the mixer
	logic                          frame;
	logic                          ack;

	modport cfg (output active, loop_en, retrig, start, end_addr, loop_start, step, vol_l, vol_r,
		input stop);
	modport voice (input active, loop_en, retrig, start, end_addr, loop_start, step, frame, ack,
		output stop, done, sample);
	modport mix (input done, sample, vol_l, vol_r, output frame, ack);
endinterface

// ==== hw/hus_mem_if.sv ====
`timescale 1ns/1ns
`include "hus_consts.svh"

// one voice to the fetch arbiter
interface hus_mem_if;
	logic                   req;        // held until valid
	logic [`HUS_ADDR_W-2:0] word_addr;
	logic                   valid;      // one cycle
	logic [`HUS_MEM_W-1:0]  data;

	modport client
	(
		output req, word_addr,
		input  valid, data
	);

	modport server
	(
		input  req, word_addr,
		output valid, data
	);
endinterface

// ==== hw/hus_regs.sv ====
`timescale 1ns/1ns
`include "hus_consts.svh"

module hus_regs
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pslverr,
	hus_voice_if.cfg    voices [`HUS_CHANNELS]
);
	import hus_pkg::*;

	localparam int CH_W = $clog2(`HUS_CHANNELS);

	logic [`HUS_CHANNELS-1:0] active;
	logic [`HUS_CHANNELS-1:0] loop_en;
	logic [`HUS_CHANNELS-1:0] retrig;
	logic [`HUS_CHANNELS-1:0] stop_v;
	logic [`HUS_ADDR_W-1:0]   start_r [`HUS_CHANNELS];
	logic [`HUS_ADDR_W-1:0]   end_r [`HUS_CHANNELS];
	logic [`HUS_ADDR_W-1:0]   loop_r [`HUS_CHANNELS];
	logic [`HUS_STEP_W-1:0]   step_r [`HUS_CHANNELS];
	logic [`HUS_VOL_W-1:0]    vol_l_r [`HUS_CHANNELS];
	logic [`HUS_VOL_W-1:0]    vol_r_r [`HUS_CHANNELS];

	logic [2:0]      ch;
	logic [CH_W-1:0] ch_sel;
	hus_reg_e        reg_idx;
	logic            mapped;
	logic            access;
	logic            wr;

	assign ch      = paddr[7:5];
	assign ch_sel  = ch[CH_W-1:0];
	assign reg_idx = hus_reg_e'(paddr[2 +: `HUS_IDX_W]);
	assign mapped  = (ch < 3'(`HUS_CHANNELS)) && (reg_idx <= reg_vol);  // 6 and 7 unmapped
	assign access  = psel && penable;
	assign wr      = access && pwrite && mapped;
	assign pslverr = access && !mapped;

	always_ff @(posedge clk)
		if (!rst_n)
		begin
			active  <= '0;
			loop_en <= '0;
			retrig  <= '0;
		end
		else
		begin
			retrig <= '0;
			active <= active & ~stop_v;  // voice ran off the end
			if (wr && reg_idx == reg_ctrl)
			begin
				active[ch_sel]  <= pwdata[0];  // host write beats stop
				loop_en[ch_sel] <= pwdata[1];
				retrig[ch_sel]  <= pwdata[2];
			end
		end

	// channel setup words
	always_ff @(posedge clk)
		if (!rst_n)
		begin
			for (int i = 0; i < `HUS_CHANNELS; i++)
			begin
				start_r[i] <= '0;
				end_r[i]   <= '0;
				loop_r[i]  <= '0;
				step_r[i]  <= '0;
				vol_l_r[i] <= '0;
				vol_r_r[i] <= '0;
			end
		end
		else if (wr)
			case (reg_idx)
				reg_start:      start_r[ch_sel] <= pwdata[`HUS_ADDR_W-1:0];
				reg_end_addr:   end_r[ch_sel]   <= pwdata[`HUS_ADDR_W-1:0];
				reg_loop_start: loop_r[ch_sel]  <= pwdata[`HUS_ADDR_W-1:0];
				reg_step:       step_r[ch_sel]  <= pwdata[`HUS_STEP_W-1:0];
				reg_vol:
				begin
					vol_l_r[ch_sel] <= pwdata[`HUS_VOL_W-1:0];
					vol_r_r[ch_sel] <= pwdata[2*`HUS_VOL_W-1:`HUS_VOL_W];
				end
				default: ;
			endcase

	always_comb
	begin
		prdata = '0;
		if (mapped)
			case (reg_idx)
				reg_ctrl:       prdata = {30'b0, loop_en[ch_sel], active[ch_sel]};  // retrig reads 0
				reg_start:      prdata = 32'(start_r[ch_sel]);
				reg_end_addr:   prdata = 32'(end_r[ch_sel]);
				reg_loop_start: prdata = 32'(loop_r[ch_sel]);
				reg_step:       prdata = 32'(step_r[ch_sel]);
				reg_vol:        prdata = 32'({vol_r_r[ch_sel], vol_l_r[ch_sel]});
				default:        prdata = '0;
			endcase
	end

	for (genvar g = 0; g < `HUS_CHANNELS; g++)
	begin : g_ch
		assign voices[g].active     = active[g];
		assign voices[g].loop_en    = loop_en[g];
		assign voices[g].retrig     = retrig[g];
		assign voices[g].start      = start_r[g];
		assign voices[g].end_addr   = end_r[g];
		assign voices[g].loop_start = loop_r[g];
		assign voices[g].step       = step_r[g];
		assign voices[g].vol_l      = vol_l_r[g];
		assign voices[g].vol_r      = vol_r_r[g];
		assign stop_v[g]            = voices[g].stop;
	end
endmodule

// ==== hw/hus_voice.sv ====
`timescale 1ns/1ns
`include "hus_consts.svh"

module hus_voice
(
	input  logic       clk,
	input  logic       rst_n,
	hus_voice_if.voice vif,
	hus_mem_if.client  mem
);
	import hus_pkg::*;

	localparam int POS_W = `HUS_ADDR_W + `HUS_FRAC_W;

	voice_state_e state;
	hus_pos_t     pos;
	hus_pos_t     pos_step;
	hus_pos_t     pos_next;

	logic [`HUS_ADDR_W-1:0]       int_next;
	logic                         past_end;
	logic                         retrig_pend;
	logic                         stop_q;
	logic signed [`HUS_SMP_W-1:0] sample_q;

	assign pos_step = pos + hus_pos_t'(vif.step);
	assign int_next = pos_step[POS_W-1:`HUS_FRAC_W];
	assign past_end = int_next > vif.end_addr;

	always_comb
	begin
		pos_next = pos_step;
		if (past_end && vif.loop_en)
			pos_next = {vif.loop_start, {`HUS_FRAC_W{1'b0}}};  // loop point, fraction dropped
	end

	// word holding the current byte, bit 0 picks the lane
	assign mem.req       = (state == v_fetch);
	assign mem.word_addr = pos[POS_W-1:`HUS_FRAC_W+1];

	assign vif.done   = (state == v_ready);
	assign vif.stop   = stop_q;
	assign vif.sample = sample_q;

	always_ff @(posedge clk)
		if (!rst_n)
		begin
			state       <= v_idle;
			pos         <= '0;
			retrig_pend <= 1'b0;
			stop_q      <= 1'b0;
		end
		else
		begin
			stop_q <= 1'b0;
			case (state)
				v_idle:
					if (vif.frame)
					begin
						if (vif.active)
						begin
							if (retrig_pend)
							begin
								pos         <= {vif.start, {`HUS_FRAC_W{1'b0}}};
								retrig_pend <= 1'b0;
							end
							state <= v_fetch;
						end
						else
							state <= v_ready;  // silent voice, sample forced to 0
					end
				v_fetch:
					if (mem.valid)
					begin
						pos    <= pos_next;
						stop_q <= past_end && !vif.loop_en;
						state  <= v_ready;
					end
				v_ready:
					if (vif.ack)
						state <= v_idle;
				default:
					state <= v_idle;
			endcase
			if (vif.retrig)
				retrig_pend <= 1'b1;  // applied at next frame
		end

	always_ff @(posedge clk)
		if (state == v_idle && vif.frame && !vif.active)
			sample_q <= '0;
		else if (state == v_fetch && mem.valid)
		begin
			if (pos[`HUS_FRAC_W])  // odd byte in high lane
				sample_q <= mem.data[`HUS_MEM_W-1:`HUS_SMP_W];
			else
				sample_q <= mem.data[`HUS_SMP_W-1:0];
		end
endmodule

// ==== hw/hus_fetch.sv ====
`timescale 1ns/1ns
`include "hus_consts.svh"

module hus_fetch
(
	input  logic                   clk,
	input  logic                   rst_n,
	hus_mem_if.server              clients [`HUS_CHANNELS],
	output logic [`HUS_ADDR_W-2:0] mem_addr,
	output logic                   mem_req,
	input  logic [`HUS_MEM_W-1:0]  mem_data,
	input  logic                   mem_valid
);
	localparam int CH_W = $clog2(`HUS_CHANNELS);

	logic [`HUS_CHANNELS-1:0] req_v;
	logic [`HUS_ADDR_W-2:0]   addr_v [`HUS_CHANNELS];
	logic [CH_W-1:0]          grant;
	logic [CH_W-1:0]          last;   // voice served most recently
	logic [CH_W-1:0]          pick;
	logic                     found;
	logic                     busy;

	// first requester after the last one served
	always_comb
	begin
		pick  = last;
		found = 1'b0;
		for (int i = 1; i <= `HUS_CHANNELS; i++)
			if (!found && req_v[(int'(last) + i) % `HUS_CHANNELS])
			begin
				pick  = CH_W'((int'(last) + i) % `HUS_CHANNELS);
				found = 1'b1;
			end
	end

	always_ff @(posedge clk)
		if (!rst_n)
		begin
			busy  <= 1'b0;
			grant <= '0;
			last  <= CH_W'(`HUS_CHANNELS - 1);  // voice 0 goes first
		end
		else if (!busy)
		begin
			busy  <= found;
			grant <= pick;
		end
		else if (mem_valid)
		begin
			busy <= 1'b0;
			last <= grant;
		end

	assign mem_req  = busy;
	assign mem_addr = addr_v[grant];

	for (genvar g = 0; g < `HUS_CHANNELS; g++)
	begin : g_client
		assign req_v[g]         = clients[g].req;
		assign addr_v[g]        = clients[g].word_addr;
		assign clients[g].valid = busy && mem_valid && (grant == CH_W'(g));
		assign clients[g].data  = mem_data;
	end
endmodule

// ==== hw/hus_mixer.sv ====
`timescale 1ns/1ns
`include "hus_consts.svh"

module hus_mixer
(
	input  logic                  clk,
	input  logic                  rst_n,
	hus_voice_if.mix              voices [`HUS_CHANNELS],
	output logic [`HUS_DAC_W-1:0] ldac,
	output logic [`HUS_DAC_W-1:0] rdac,
	output logic                  frame_done
);
	import hus_pkg::*;

	localparam int FRAME_W = $clog2(`HUS_FRAME_CYCLES);
	localparam int SUM_W   = `HUS_DAC_W + 2;  // headroom for four voices
	localparam logic signed [SUM_W-1:0] SUM_MAX = SUM_W'((1 << (`HUS_DAC_W - 1)) - 1);
	localparam logic signed [SUM_W-1:0] SUM_MIN = -SUM_W'(1 << (`HUS_DAC_W - 1));

	mix_state_e state;

	logic [FRAME_W-1:0]           frame_cnt;
	logic                         tick;
	logic                         frame_q;
	logic                         ack_q;
	logic [`HUS_CHANNELS-1:0]     done_v;
	logic signed [`HUS_DAC_W-1:0] prod_l [`HUS_CHANNELS];
	logic signed [`HUS_DAC_W-1:0] prod_r [`HUS_CHANNELS];
	logic signed [SUM_W-1:0]      sum_l;
	logic signed [SUM_W-1:0]      sum_r;

	function automatic logic [`HUS_DAC_W-1:0] sat(input logic signed [SUM_W-1:0] s);
		if (s > SUM_MAX)
			return SUM_MAX[`HUS_DAC_W-1:0];
		else if (s < SUM_MIN)
			return SUM_MIN[`HUS_DAC_W-1:0];
		return s[`HUS_DAC_W-1:0];
	endfunction

	assign tick = (frame_cnt == FRAME_W'(`HUS_FRAME_CYCLES - 1));

	for (genvar g = 0; g < `HUS_CHANNELS; g++)
	begin : g_voice
		logic signed [`HUS_DAC_W:0] mul_l;
		logic signed [`HUS_DAC_W:0] mul_r;

		assign mul_l = $signed(voices[g].sample) * $signed({1'b0, voices[g].vol_l});
		assign mul_r = $signed(voices[g].sample) * $signed({1'b0, voices[g].vol_r});
		assign prod_l[g] = mul_l[`HUS_DAC_W-1:0];  // -128*255 still fits
		assign prod_r[g] = mul_r[`HUS_DAC_W-1:0];
		assign done_v[g] = voices[g].done;
		assign voices[g].frame = frame_q;
		assign voices[g].ack   = ack_q;
	end

	always_comb
	begin
		sum_l = '0;
		sum_r = '0;
		for (int i = 0; i < `HUS_CHANNELS; i++)
		begin
			sum_l = sum_l + SUM_W'(prod_l[i]);
			sum_r = sum_r + SUM_W'(prod_r[i]);
		end
	end

	always_ff @(posedge clk)
		if (!rst_n)
		begin
			state      <= m_wait_frame;
			frame_cnt  <= '0;
			frame_q    <= 1'b0;
			ack_q      <= 1'b0;
			frame_done <= 1'b0;
			ldac       <= '0;
			rdac       <= '0;
		end
		else
		begin
			frame_cnt  <= tick ? '0 : frame_cnt + 1'b1;
			frame_q    <= 1'b0;
			ack_q      <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				m_wait_frame:
					if (tick)
					begin
						frame_q <= 1'b1;
						state   <= m_gather;
					end
				m_gather:  // ticks seen here are dropped
					if (&done_v)
					begin
						ldac       <= sat(sum_l);
						rdac       <= sat(sum_r);
						frame_done <= 1'b1;
						ack_q      <= 1'b1;
						state      <= m_sum;
					end
				m_sum:
					state <= m_wait_frame;
				default:
					state <= m_wait_frame;
			endcase
		end
endmodule

// ==== hw/hus_top.sv ====
`timescale 1ns/1ns
`include "hus_consts.svh"

module hus_top
(
	input  logic                   clk,
	input  logic                   rst_n,

	// APB slave
	input  logic [7:0]             paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pslverr,

	// sample memory, word addressed
	output logic [`HUS_ADDR_W-2:0] mem_addr,
	output logic                   mem_req,
	input  logic [`HUS_MEM_W-1:0]  mem_data,
	input  logic                   mem_valid,

	// audio out
	output logic [`HUS_DAC_W-1:0]  ldac,
	output logic [`HUS_DAC_W-1:0]  rdac,
	output logic                   frame_done
);
	hus_voice_if vif [`HUS_CHANNELS] ();
	hus_mem_if   mif [`HUS_CHANNELS] ();

	hus_regs i_regs
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pslverr (pslverr),
		.voices  (vif)
	);

	for (genvar g = 0; g < `HUS_CHANNELS; g++)
	begin : g_voice
		hus_voice i_voice
		(
			.clk   (clk),
			.rst_n (rst_n),
			.vif   (vif[g]),
			.mem   (mif[g])
		);
	end

	hus_fetch i_fetch
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.clients   (mif),
		.mem_addr  (mem_addr),
		.mem_req   (mem_req),
		.mem_data  (mem_data),
		.mem_valid (mem_valid)
	);

	hus_mixer i_mixer
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.voices     (vif),
		.ldac       (ldac),
		.rdac       (rdac),
		.frame_done (frame_done)
	);
endmodule

// ==== test/hus_tb.sv ====
`timescale 1ns/1ns
`include "hus_consts.svh"

module hus_tb;
	import hus_pkg::*;

	localparam int CLK_NS = 4;
	localparam int POS_W  = `HUS_ADDR_W + `HUS_FRAC_W;
	localparam logic [31:0] SEED = 32'hb963_67f5;

	// frames consumed by each test including sync frames
	localparam int N_SINGLE = 8;
	localparam int N_FRAC   = 40;
	localparam int N_END    = 12;
	localparam int N_SAT    = 3;
	localparam int N_ROUND  = 20;
	localparam int N_ROUNDS = 4;
	localparam int FRAMES_USED = 1 + (N_SINGLE + 1) + (N_FRAC + 1) + (N_END + 1)
		+ (2 * N_SAT + 1) + N_ROUNDS * (N_ROUND + 1);
	localparam int WATCHDOG_NS = (FRAMES_USED + 20) * `HUS_FRAME_CYCLES * CLK_NS;

	// readback mask per register with ctrl reduced to loop enable
	localparam logic [31:0] RD_MASK [6] =
		'{32'h2, 32'hff_ffff, 32'hff_ffff, 32'hff_ffff, 32'hffff, 32'hffff};

	logic                          clk;
	logic                          rst_n;
	logic [7:0]                    paddr;
	logic                          psel;
	logic                          penable;
	logic                          pwrite;
	logic [31:0]                   pwdata;
	logic [31:0]                   prdata;
	logic                          pslverr;
	logic [`HUS_ADDR_W-2:0]        mem_addr;
	logic                          mem_req;
	logic [`HUS_MEM_W-1:0]         mem_data;
	logic                          mem_valid;
	logic [`HUS_DAC_W-1:0]         ldac;
	logic [`HUS_DAC_W-1:0]         rdac;
	logic                          frame_done;

	// reference model of every channel
	hus_pos_t                      m_pos [`HUS_CHANNELS];
	logic [`HUS_CHANNELS-1:0]      m_active;
	logic [`HUS_CHANNELS-1:0]      m_loop;
	logic [`HUS_CHANNELS-1:0]      m_retrig;
	logic [`HUS_ADDR_W-1:0]        m_start [`HUS_CHANNELS];
	logic [`HUS_ADDR_W-1:0]        m_end [`HUS_CHANNELS];
	logic [`HUS_ADDR_W-1:0]        m_loop_start [`HUS_CHANNELS];
	logic [`HUS_STEP_W-1:0]        m_step [`HUS_CHANNELS];
	logic [`HUS_VOL_W-1:0]         m_vol_l [`HUS_CHANNELS];
	logic [`HUS_VOL_W-1:0]         m_vol_r [`HUS_CHANNELS];

	string cur_test;
	int    errors;
	int    n_checks;
	int    n_tests;
	int    n_failed;
	int    test_err0;

	hus_top i_hus_top
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pslverr    (pslverr),
		.mem_addr   (mem_addr),
		.mem_req    (mem_req),
		.mem_data   (mem_data),
		.mem_valid  (mem_valid),
		.ldac       (ldac),
		.rdac       (rdac),
		.frame_done (frame_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("TB FAILED");
		$finish;
	end

	// sample memory contents with near full-scale bytes in the top eighth
	function automatic logic [`HUS_MEM_W-1:0] mem_word(input logic [`HUS_ADDR_W-2:0] a);
		logic [31:0] h;
		h = {9'b0, a} * 32'h9e37_79b1;
		if (a[`HUS_ADDR_W-2 -: 3] == 3'b111)
			return 16'h807f ^ {7'b0, ^a, 7'b0, ^a};  // high byte -128 or -127
		return h[31:16] ^ h[15:0];
	endfunction

	// memory responder with 1 to 4 cycles of latency
	initial
	begin
		int lat;
		mem_valid = 1'b0;
		mem_data  = '0;
		@(posedge rst_n);
		forever
		begin
			@(posedge clk);
			#1;
			if (mem_req)
			begin
				lat = 1 + int'($urandom % 4);
				repeat (lat - 1)
				begin
					@(posedge clk);
					#1;
				end
				mem_valid = 1'b1;
				mem_data  = mem_word(mem_addr);
				@(posedge clk);
				#1;
				mem_valid = 1'b0;
			end
		end
	end

	function automatic logic [`HUS_DAC_W-1:0] clamp(input int s);
		if (s > 32767)
			return 16'h7fff;
		if (s < -32768)
			return 16'h8000;
		return 16'(s);
	endfunction

	// one frame of every voice giving the expected dac words
	task automatic model_frame(output logic [`HUS_DAC_W-1:0] el, output logic [`HUS_DAC_W-1:0] er);
		int                    sl;
		int                    sr;
		logic [`HUS_MEM_W-1:0] w;
		logic signed [7:0]     s;
		hus_pos_t              nxt;
		sl = 0;
		sr = 0;
		for (int ch = 0; ch < `HUS_CHANNELS; ch++)
		begin
			s = '0;
			if (m_active[ch])
			begin
				if (m_retrig[ch])
				begin
					m_pos[ch]    = {m_start[ch], 8'h00};
					m_retrig[ch] = 1'b0;
				end
				w = mem_word(m_pos[ch][POS_W-1:`HUS_FRAC_W+1]);
				s = m_pos[ch][`HUS_FRAC_W] ? w[15:8] : w[7:0];  // odd byte is the high lane
				nxt = m_pos[ch] + {16'b0, m_step[ch]};
				if (nxt[POS_W-1:`HUS_FRAC_W] > m_end[ch])
				begin
					if (m_loop[ch])
						nxt = {m_loop_start[ch], 8'h00};
					else
						m_active[ch] = 1'b0;
				end
				m_pos[ch] = nxt;
			end
			sl = sl + int'(s) * int'(m_vol_l[ch]);
			sr = sr + int'(s) * int'(m_vol_r[ch]);
		end
		el = clamp(sl);
		er = clamp(sr);
	endtask

	task automatic mirror_write(input int ch, input logic [`HUS_IDX_W-1:0] idx,
		input logic [31:0] d);
		case (idx)
			reg_ctrl:
			begin
				m_active[ch] = d[0];
				m_loop[ch]   = d[1];
				if (d[2])
					m_retrig[ch] = 1'b1;
			end
			reg_start:      m_start[ch]      = d[`HUS_ADDR_W-1:0];
			reg_end_addr:   m_end[ch]        = d[`HUS_ADDR_W-1:0];
			reg_loop_start: m_loop_start[ch] = d[`HUS_ADDR_W-1:0];
			reg_step:       m_step[ch]       = d[`HUS_STEP_W-1:0];
			reg_vol:
			begin
				m_vol_l[ch] = d[7:0];
				m_vol_r[ch] = d[15:8];
			end
			default: ;
		endcase
	endtask

	task automatic check_apb(input string what, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_dac(input string what, input logic [`HUS_DAC_W-1:0] exp_l,
		input logic [`HUS_DAC_W-1:0] exp_r, input logic [`HUS_DAC_W-1:0] act_l,
		input logic [`HUS_DAC_W-1:0] act_r);
		n_checks++;
		if (act_l !== exp_l || act_r !== exp_r)
		begin
			errors++;
			$display("ERROR %s %s: expected l=%0d r=%0d, actual l=%0d r=%0d", cur_test, what,
				$signed(exp_l), $signed(exp_r), $signed(act_l), $signed(act_r));
		end
	endtask

	task automatic check_active(input string what, input logic [`HUS_CHANNELS-1:0] exp,
		input logic [`HUS_CHANNELS-1:0] act);
		n_checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERROR %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_err(input string what, input logic exp, input logic act);
		n_checks++;
		if (act !== exp)
		begin
			errors++;
			$display("ERROR %s %s pslverr: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic apb_write(input int ch, input logic [`HUS_IDX_W-1:0] idx,
		input logic [31:0] d, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = {ch[2:0], idx, 2'b00};
		pwdata  = d;
		@(posedge clk);
		#1 penable = 1'b1;
		#1 err = pslverr;
		@(posedge clk);  // register takes the value here
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		if (ch < `HUS_CHANNELS)
			mirror_write(ch, idx, d);
	endtask

	task automatic apb_read(input int ch, input logic [`HUS_IDX_W-1:0] idx,
		output logic [31:0] data, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = {ch[2:0], idx, 2'b00};
		@(posedge clk);
		#1 penable = 1'b1;
		#1;
		data = prdata;
		err  = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic program_voice(input int ch, input logic [`HUS_ADDR_W-1:0] start,
		input logic [`HUS_ADDR_W-1:0] stop_at, input logic [`HUS_ADDR_W-1:0] loop_at,
		input logic [`HUS_STEP_W-1:0] step, input logic [15:0] vol, input logic [2:0] ctrl);
		logic err;
		apb_write(ch, reg_start, 32'(start), err);
		apb_write(ch, reg_end_addr, 32'(stop_at), err);
		apb_write(ch, reg_loop_start, 32'(loop_at), err);
		apb_write(ch, reg_step, 32'(step), err);
		apb_write(ch, reg_vol, 32'(vol), err);
		apb_write(ch, reg_ctrl, 32'(ctrl), err);  // ctrl last so the retrigger sees the rest
	endtask

	task automatic read_active(output logic [`HUS_CHANNELS-1:0] act);
		logic [31:0] d;
		logic        err;
		for (int ch = 0; ch < `HUS_CHANNELS; ch++)
		begin
			apb_read(ch, reg_ctrl, d, err);
			act[ch] = d[0];
		end
	endtask

	// waits for the next frame_done and compares it with the model
	task automatic frame_step();
		logic [`HUS_DAC_W-1:0] el;
		logic [`HUS_DAC_W-1:0] er;
		@(posedge clk);
		#1;
		while (!frame_done)
		begin
			@(posedge clk);
			#1;
		end
		model_frame(el, er);
		check_dac("frame", el, er, ldac, rdac);
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		n_tests++;
		if (errors == test_err0)
			$display("test %s: ok", cur_test);
		else
		begin
			n_failed++;
			$display("test %s: %0d errors", cur_test, errors - test_err0);
		end
	endtask

	task automatic test_regs();
		logic [31:0]              vals [6];
		logic [31:0]              rd;
		logic                     err;
		logic [`HUS_CHANNELS-1:0] act;
		begin_test("reg_access");
		check_dac("after reset", '0, '0, ldac, rdac);
		read_active(act);
		check_active("after reset", '0, act);
		if (mem_req !== 1'b0 || frame_done !== 1'b0)
		begin
			errors++;
			$display("mem_req or frame_done is not low after reset");
		end
		frame_step();
		for (int ch = 0; ch < `HUS_CHANNELS; ch++)
		begin
			vals[0] = ($urandom & ~32'h1) | 32'h6;  // inactive, loop on, retrigger
			for (int i = 1; i < 6; i++)
				vals[i] = $urandom;
			for (int i = 0; i < 6; i++)
			begin
				apb_write(ch, 3'(i), vals[i], err);
				check_err("mapped write", 1'b0, err);
			end
			for (int i = 0; i < 6; i++)
			begin
				apb_read(ch, 3'(i), rd, err);
				check_err("mapped read", 1'b0, err);
				check_apb("readback", vals[i] & RD_MASK[i], rd);
			end
		end
		for (int i = 6; i < 8; i++)
		begin
			apb_write(0, 3'(i), $urandom, err);
			check_err("unmapped write", 1'b1, err);
			apb_read(0, 3'(i), rd, err);
			check_err("unmapped read", 1'b1, err);
			check_apb("unmapped data", 32'h0, rd);
		end
		apb_read(5, reg_start, rd, err);  // no such channel
		check_err("channel 5 read", 1'b1, err);
		check_apb("channel 5 data", 32'h0, rd);
		end_test();
	endtask

	task automatic test_single();
		begin_test("single_voice");
		frame_step();
		program_voice(0, 24'h00_0100, 24'hff_ffff, 24'h00_0100, 16'h0100, 16'h00ff, 3'b101);
		repeat (N_SINGLE) frame_step();
		end_test();
	endtask

	task automatic test_frac();
		logic [`HUS_ADDR_W-1:0] start;
		begin_test("fractional_step");
		frame_step();
		start = 24'($urandom) & 24'h7f_ff00;
		program_voice(0, start, start + 24'h1000, start, 16'h0155, 16'h64c8, 3'b101);
		repeat (N_FRAC) frame_step();
		end_test();
	endtask

	task automatic test_end();
		logic [`HUS_CHANNELS-1:0] act;
		begin_test("end_address");
		frame_step();
		program_voice(0, 24'h00_1000, 24'h00_1004, 24'h00_1000, 16'h0100, 16'hffff, 3'b101);
		program_voice(1, 24'h00_2000, 24'h00_2006, 24'h00_2002, 16'h0180, 16'h3264, 3'b111);
		repeat (N_END)
		begin
			frame_step();
			read_active(act);
			check_active("active bits", m_active, act);
		end
		check_active("voice 0 stopped", 4'b0010, act);
		end_test();
	endtask

	task automatic test_sat();
		logic err;
		begin_test("saturation");
		frame_step();
		for (int ch = 0; ch < `HUS_CHANNELS; ch++)
			program_voice(ch, 24'he0_0000, 24'hff_ffff, 24'he0_0000, 16'h0000, 16'hffff, 3'b101);
		repeat (N_SAT) frame_step();
		check_dac("positive limit", 16'h7fff, 16'h7fff, ldac, rdac);
		for (int ch = 0; ch < `HUS_CHANNELS; ch++)
		begin
			apb_write(ch, reg_start, 32'h00e0_0001, err);  // odd byte is near -128
			apb_write(ch, reg_ctrl, 32'h5, err);
		end
		repeat (N_SAT) frame_step();
		check_dac("negative limit", 16'h8000, 16'h8000, ldac, rdac);
		end_test();
	endtask

	task automatic test_random();
		logic [`HUS_ADDR_W-1:0]   start;
		logic [`HUS_ADDR_W-1:0]   len;
		logic [`HUS_CHANNELS-1:0] act;
		logic [2:0]               ctrl;
		begin_test("random_programs");
		for (int r = 0; r < N_ROUNDS; r++)
		begin
			frame_step();
			for (int ch = 0; ch < `HUS_CHANNELS; ch++)
			begin
				start = 24'($urandom % 32'hff_0000);
				len   = 24'($urandom % 600);
				ctrl  = {1'b1, 1'($urandom), 1'(($urandom % 4) != 0)};
				program_voice(ch, start, start + len, start + 24'($urandom % (32'(len) + 1)),
					16'($urandom % 32'h0400) + 16'h0020, 16'($urandom), ctrl);
			end
			repeat (N_ROUND) frame_step();
			read_active(act);
			check_active("active bits", m_active, act);
		end
		end_test();
	endtask

	initial
	begin
		void'($urandom(SEED));
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		errors   = 0;
		n_checks = 0;
		n_tests  = 0;
		n_failed = 0;
		m_active = '0;
		m_loop   = '0;
		m_retrig = '0;
		for (int ch = 0; ch < `HUS_CHANNELS; ch++)
		begin
			m_pos[ch]        = '0;
			m_start[ch]      = '0;
			m_end[ch]        = '0;
			m_loop_start[ch] = '0;
			m_step[ch]       = '0;
			m_vol_l[ch]      = '0;
			m_vol_r[ch]      = '0;
		end
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		test_regs();
		test_single();
		test_frac();
		test_end();
		test_sat();
		test_random();
		$display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, n_checks,
			errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end
endmodule

// ==== filelist.f ====
+incdir+include
hw/hus_pkg.sv
hw/hus_voice_if.sv
hw/hus_mem_if.sv
hw/hus_regs.sv
hw/hus_voice.sv
hw/hus_fetch.sv
hw/hus_mixer.sv
hw/hus_top.sv
test/hus_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module hus_tb -f filelist.f -o hus_sim \
	&& ./obj_dir/hus_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && exit 0 || exit 1
